// ==== Bender.yml ====
package:
  name: datapath

sources:
  - design/mipsPkg.sv
  - design/hazardIf.sv
  - design/pipeReg.sv
  - design/mainDecoder.sv
  - design/regFile.sv
  - design/alu.sv
  - design/hazardUnit.sv
  - design/datapath.sv
  - target: test
    files:
      - dv/datapathTb.sv

// ==== design/alu.sv ====
module alu (
    input  mipsPkg::aluOpT op_i,
    input  logic [31:0]    a_i,
    input  logic [31:0]    b_i,
    output logic [31:0]    result_o,
    output logic           zero_o
);
    import mipsPkg::*;

    logic signedLess;

    assign signedLess = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            aluAdd:  result_o = a_i + b_i;
            aluSub:  result_o = a_i - b_i;
            aluAnd:  result_o = a_i & b_i;
            aluOr:   result_o = a_i | b_i;
            aluSlt:  result_o = {31'd0, signedLess};
            aluLui:  result_o = {b_i[15:0], 16'h0000};
            default: result_o = 32'd0;
        endcase
    end

    assign zero_o = (result_o == 32'd0); // beq taken with aluSub

endmodule

// ==== design/datapath.sv ====
module datapath (
    input  logic        clk,
    input  logic        arstN_i,

    // instruction fetch
    output logic [31:0] instAddr_o,
    output logic        instEn_o,
    input  logic [31:0] instrF_i,
    input  logic        iCacheStall_i,

    // data memory
    output logic        memEn_o,
    output logic [31:0] memAddr_o,
    input  logic [31:0] memRdata_i,
    output logic [3:0]  memWen_o,
    output logic [31:0] memWdata_o,
    input  logic        dCacheStall_i,

    // writeback trace
    output logic [31:0] debugWbPc_o,
    output logic [3:0]  debugWbRfWen_o,
    output logic [4:0]  debugWbRfWnum_o,
    output logic [31:0] debugWbRfWdata_o
);
    import mipsPkg::*;

    logic [31:0] pcF, pcPlus4F, pcNext;
    logic        instEn;
    ifIdT        ifIdNext, ifIdD;
    idExT        idExNext, idExE;
    exMemT       exMemNext, exMemM;
    memWbT       memWbNext, memWbW;

    ctrlT        ctrlD;
    logic [31:0] immD, rsValD, rtValD;
    logic [4:0]  rsD, rtD, rdD;

    logic [31:0] srcAE, rtValE, srcBE, aluResultE;
    logic [31:0] branchTargetE;
    logic        zeroE, redirectE;

    logic [31:0] resultM;
    logic        rfWe;

    hazardIf hz (.clk(clk), .arstN_i(arstN_i));

    function automatic logic [31:0] fwdMux(input fwdSelT sel, input logic [31:0] rf,
                                           input logic [31:0] mem, input logic [31:0] wb);
        case (sel)
            fwdMem:  return mem;
            fwdWb:   return wb;
            default: return rf;
        endcase
    endfunction

    // IF
    assign pcPlus4F = pcF + 32'd4;
    assign pcNext   = !redirectE ? pcPlus4F
                    : idExE.ctrl.jump ? idExE.jumpTarget : branchTargetE;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pcF    <= resetPc;
            instEn <= 1'b0;
        end else begin
            instEn <= 1'b1;  // first fetch one cycle after reset
            if (instEn && !hz.stallF) begin
                pcF <= pcNext;
            end
        end
    end

    assign instAddr_o = pcF;
    assign instEn_o   = instEn;
    assign ifIdNext   = instEn ? '{pc: pcF, pcPlus4: pcPlus4F, instr: instrF_i} : '0;

    pipeReg #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .arstN_i(arstN_i),
        .stall_i(hz.stallD), .flush_i(hz.flushD),
        .d_i(ifIdNext), .q_o(ifIdD)
    );

    // ID
    assign rsD = ifIdD.instr[25:21];
    assign rtD = ifIdD.instr[20:16];
    assign rdD = ifIdD.instr[15:11];

    mainDecoder mainDecoder_inst (.instr_i(ifIdD.instr), .ctrl_o(ctrlD), .imm_o(immD));

    regFile regFile_inst (
        .clk(clk), .arstN_i(arstN_i),
        .we_i(rfWe), .waddr_i(memWbW.writeReg), .wdata_i(memWbW.result),
        .raddr1_i(rsD), .raddr2_i(rtD),
        .rdata1_o(rsValD), .rdata2_o(rtValD)
    );

    always_comb begin
        idExNext.pc         = ifIdD.pc;
        idExNext.pcPlus4    = ifIdD.pcPlus4;
        idExNext.rsVal      = rsValD;
        idExNext.rtVal      = rtValD;
        idExNext.rs         = rsD;
        idExNext.rt         = rtD;
        idExNext.writeReg   = ctrlD.regDstRd ? rdD : rtD;
        idExNext.imm        = immD;
        idExNext.jumpTarget = {ifIdD.pcPlus4[31:28], ifIdD.instr[25:0], 2'b00};
        idExNext.ctrl       = ctrlD;
    end

    pipeReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .arstN_i(arstN_i),
        .stall_i(hz.stallE), .flush_i(hz.flushE),
        .d_i(idExNext), .q_o(idExE)
    );

    // EX
    assign srcAE  = fwdMux(hz.fwdA, idExE.rsVal, resultM, memWbW.result);
    assign rtValE = fwdMux(hz.fwdB, idExE.rtVal, resultM, memWbW.result);
    assign srcBE  = idExE.ctrl.aluSrcImm ? idExE.imm : rtValE;

    alu alu_inst (
        .op_i(idExE.ctrl.aluOp), .a_i(srcAE), .b_i(srcBE),
        .result_o(aluResultE), .zero_o(zeroE)
    );

    assign branchTargetE = idExE.pcPlus4 + {idExE.imm[29:0], 2'b00};
    assign redirectE     = (idExE.ctrl.branch & zeroE) | idExE.ctrl.jump; // no delay slot

    always_comb begin
        exMemNext.pc        = idExE.pc;
        exMemNext.aluResult = aluResultE;
        exMemNext.storeData = rtValE;
        exMemNext.writeReg  = idExE.writeReg;
        exMemNext.ctrl      = idExE.ctrl;
    end

    pipeReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .arstN_i(arstN_i),
        .stall_i(hz.stallM), .flush_i(hz.flushM),
        .d_i(exMemNext), .q_o(exMemM)
    );

    // MEM, load data comes back in the same cycle
    assign memEn_o    = exMemM.ctrl.memRead | exMemM.ctrl.memWrite;
    assign memAddr_o  = exMemM.aluResult;
    assign memWen_o   = {4{exMemM.ctrl.memWrite}};
    assign memWdata_o = exMemM.storeData;
    assign resultM    = exMemM.ctrl.memRead ? memRdata_i : exMemM.aluResult;

    always_comb begin
        memWbNext.pc       = exMemM.pc;
        memWbNext.result   = resultM;
        memWbNext.writeReg = exMemM.writeReg;
        memWbNext.regWrite = exMemM.ctrl.regWrite;
    end

    pipeReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .arstN_i(arstN_i),
        .stall_i(hz.stallW), .flush_i(1'b0),
        .d_i(memWbNext), .q_o(memWbW)
    );

    // WB, held off while frozen
    assign rfWe = memWbW.regWrite & ~hz.stallW;

    assign debugWbPc_o      = memWbW.pc;
    assign debugWbRfWen_o   = {4{rfWe && memWbW.writeReg != 5'd0}};
    assign debugWbRfWnum_o  = memWbW.writeReg;
    assign debugWbRfWdata_o = memWbW.result;

    // hazard unit hookup
    assign hz.rsD         = rsD;
    assign hz.rtD         = rtD;
    assign hz.rsE         = idExE.rs;
    assign hz.rtE         = idExE.rt;
    assign hz.writeRegE   = idExE.writeReg;
    assign hz.memReadE    = idExE.ctrl.memRead;
    assign hz.writeRegM   = exMemM.writeReg;
    assign hz.memReadM    = exMemM.ctrl.memRead;
    assign hz.regWriteM   = exMemM.ctrl.regWrite;
    assign hz.writeRegW   = memWbW.writeReg;
    assign hz.regWriteW   = memWbW.regWrite;
    assign hz.redirectE   = redirectE;
    assign hz.iCacheStall = iCacheStall_i;
    assign hz.dCacheStall = dCacheStall_i;

    hazardUnit hazardUnit_inst (.hz(hz.unit));

endmodule

// ==== design/hazardIf.sv ====
interface hazardIf (
    input logic clk,
    input logic arstN_i
);
    import mipsPkg::*;

    // pipeline state seen by the hazard unit
    logic [4:0] rsD, rtD;
    logic [4:0] rsE, rtE;
    logic [4:0] writeRegE, writeRegM, writeRegW;
    logic       memReadE, memReadM;
    logic       regWriteM, regWriteW;
    logic       redirectE;   // taken BEQ or J in EX
    logic       iCacheStall, dCacheStall;

    // decisions back to the pipeline
    logic       stallF, stallD, stallE, stallM, stallW;
    logic       flushD, flushE, flushM;
    fwdSelT     fwdA, fwdB;

    modport unit (
        input  clk, arstN_i,
        input  rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
        input  memReadE, memReadM, regWriteM, regWriteW, redirectE,
        input  iCacheStall, dCacheStall,
        output stallF, stallD, stallE, stallM, stallW,
        output flushD, flushE, flushM, fwdA, fwdB
    );

    modport pipe (
        output rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
        output memReadE, memReadM, regWriteM, regWriteW, redirectE,
        output iCacheStall, dCacheStall,
        input  stallF, stallD, stallE, stallM, stallW,
        input  flushD, flushE, flushM, fwdA, fwdB
    );

endinterface

// ==== design/hazardUnit.sv ====
module hazardUnit (
    hazardIf.unit hz
);
    import mipsPkg::*;

    logic freeze;
    logic loadUse;

    // MEM is younger so it takes priority over WB
    function automatic fwdSelT pickSource(input logic [4:0] src);
        if (src != 5'd0 && hz.regWriteM && hz.writeRegM == src) begin
            return fwdMem;
        end else if (src != 5'd0 && hz.regWriteW && hz.writeRegW == src) begin
            return fwdWb;
        end
        return fwdRf;
    endfunction

    assign freeze  = hz.iCacheStall | hz.dCacheStall;
    // load in EX, consumer sitting in ID
    assign loadUse = hz.memReadE && hz.writeRegE != 5'd0
                     && (hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD);

    assign hz.fwdA = pickSource(hz.rsE);
    assign hz.fwdB = pickSource(hz.rtE);

    assign hz.stallF = freeze | loadUse;
    assign hz.stallD = freeze | loadUse;
    assign hz.stallE = freeze;
    assign hz.stallM = freeze;
    assign hz.stallW = freeze;

    // flushes wait until the freeze lifts
    assign hz.flushD = hz.redirectE & ~freeze;
    assign hz.flushE = (hz.redirectE | loadUse) & ~freeze;
    assign hz.flushM = 1'b0;  // EX results are never squashed

    redirectNotLoadUse: assert property (
        @(posedge hz.clk) disable iff (!hz.arstN_i)
        !(hz.redirectE && loadUse)
    ) else $error("hazardUnit: redirect and load-use together");

    // the interlock one cycle earlier keeps load data off the MEM bypass
    loadNeverForwardedFromMem: assert property (
        @(posedge hz.clk) disable iff (!hz.arstN_i)
        !(hz.memReadM && hz.writeRegM != 5'd0
          && (hz.writeRegM == hz.rsE || hz.writeRegM == hz.rtE))
    ) else $error("hazardUnit: EX consumes a load still in MEM");

endmodule

// ==== design/mainDecoder.sv ====
module mainDecoder (
    input  logic [31:0]   instr_i,
    output mipsPkg::ctrlT ctrl_o,
    output logic [31:0]   imm_o
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       zeroExt;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    always_comb begin
        ctrl_o  = '0;
        zeroExt = 1'b0;
        case (opcode)
            opRtype: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.regDstRd = 1'b1;
                case (funct)
                    fnAddu:  ctrl_o.aluOp = aluAdd;
                    fnSubu:  ctrl_o.aluOp = aluSub;
                    fnAnd:   ctrl_o.aluOp = aluAnd;
                    fnOr:    ctrl_o.aluOp = aluOr;
                    fnSlt:   ctrl_o.aluOp = aluSlt;
                    default: ctrl_o = '0;  // includes sll $0 nop
                endcase
            end
            opAddiu: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = aluAdd;
            end
            opOri: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = aluOr;
                zeroExt          = 1'b1;
            end
            opLui: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = aluLui;  // alu moves imm to upper half
                zeroExt          = 1'b1;
            end
            opLw: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.memRead   = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = aluAdd;  // base + offset
            end
            opSw: begin
                ctrl_o.memWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = aluAdd;
            end
            opBeq: begin
                ctrl_o.branch = 1'b1;
                ctrl_o.aluOp  = aluSub;  // equal when difference is zero
            end
            opJ: begin
                ctrl_o.jump = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

    assign imm_o = zeroExt ? {16'h0000, instr_i[15:0]}
                           : {{16{instr_i[15]}}, instr_i[15:0]};

endmodule

// ==== design/mipsPkg.sv ====
package mipsPkg;

    localparam logic [31:0] resetPc = 32'hBFC0_0000; // first fetch address

    // primary opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0D;
    localparam logic [5:0] opLui   = 6'h0F;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2B;

    // funct field of R-type
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2A;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        fwdRf,  // value read in ID
        fwdMem, // MEM stage result
        fwdWb   // WB stage result
    } fwdSelT;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm; // operand b from immediate
        logic  regDstRd;  // write rd, else rt
        logic  branch;
        logic  jump;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pcPlus4;
        logic [31:0] instr;
    } ifIdT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pcPlus4;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  writeReg;
        logic [31:0] imm;
        logic [31:0] jumpTarget;
        ctrlT        ctrl;
    } idExT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic [4:0]  writeReg;
        ctrlT        ctrl;
    } exMemT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  writeReg;
        logic        regWrite;
    } memWbT;

endpackage

// ==== design/pipeReg.sv ====
module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    arstN_i,
    input  logic    stall_i,
    input  logic    flush_i,
    input  payloadT d_i,
    output payloadT q_o
);

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;  // bubble, every control bit inactive
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

    // hazard unit must never squash a stage it is also holding
    stallFlushExclusive: assert property (
        @(posedge clk) disable iff (!arstN_i)
        !(stall_i && flush_i)
    ) else $error("pipeReg: stall and flush requested together");

endmodule

// ==== design/regFile.sv ====
module regFile (
    input  logic        clk,
    input  logic        arstN_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o
);

    logic [31:0] regs [32];

    // $0 is hardwired, a WB write in this cycle is seen by ID
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end else if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = readPort(raddr1_i);
    assign rdata2_o = readPort(raddr2_i);

    writeAddrKnown: assert property (
        @(posedge clk) disable iff (!arstN_i)
        we_i |-> !$isunknown(waddr_i)
    ) else $error("regFile: write with unknown address");

endmodule

// ==== dv/datapathTb.sv ====
module datapathTb;
    import mipsPkg::*;

    localparam int imemWords = 32;
    localparam int dmemWords = 64;
    localparam int numRetire = 17;
    localparam int numStores = 2;
    localparam int waitLimit = 200;  // cycles allowed per retirement

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] data;
    } retireT;

    logic        clk;
    logic        arstN;
    logic [31:0] instrF;
    logic        iCacheStall;
    logic [31:0] memRdata;
    logic        dCacheStall;
    logic [31:0] instAddr;
    logic        instEn;
    logic        memEn;
    logic [31:0] memAddr;
    logic [3:0]  memWen;
    logic [31:0] memWdata;
    logic [31:0] debugWbPc;
    logic [3:0]  debugWbRfWen;
    logic [4:0]  debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    logic [31:0] imem [imemWords];
    logic [31:0] dmem [dmemWords];
    integer      seed;
    int          storeCount;
    int          extraWb;

    // program order without a delay slot so skipped slots never retire
    retireT expRetire [numRetire] = '{
        '{32'hBFC0_0000, 5'd1,  32'h0000_0005},
        '{32'hBFC0_0004, 5'd2,  32'hFFFF_FFFD},
        '{32'hBFC0_0008, 5'd3,  32'h0000_0002},
        '{32'hBFC0_000C, 5'd4,  32'hFFFF_FFFD},
        '{32'hBFC0_0010, 5'd5,  32'h0000_F0FF},
        '{32'hBFC0_0014, 5'd6,  32'h1234_0000},
        '{32'hBFC0_0018, 5'd7,  32'h1234_F0FF},
        '{32'hBFC0_001C, 5'd8,  32'h1234_F0FD},
        '{32'hBFC0_0020, 5'd9,  32'h0000_0001},
        '{32'hBFC0_0024, 5'd10, 32'h0000_0000},
        '{32'hBFC0_002C, 5'd11, 32'h1234_F0FF},
        '{32'hBFC0_0030, 5'd12, 32'h1234_F104},
        '{32'hBFC0_0038, 5'd13, 32'h0000_0005},
        '{32'hBFC0_0040, 5'd14, 32'h0000_0001},
        '{32'hBFC0_0050, 5'd17, 32'h0000_0077},
        '{32'hBFC0_0060, 5'd20, 32'h0000_0009},
        '{32'hBFC0_0068, 5'd21, 32'h0000_0009}
    };
    logic [31:0] expStoreAddr [numStores] = '{32'h0000_0010, 32'h0000_0014};
    logic [31:0] expStoreData [numStores] = '{32'h1234_F0FF, 32'h0000_0009};

    datapath datapath_inst (
        .clk(clk), .arstN_i(arstN),
        .instAddr_o(instAddr), .instEn_o(instEn), .instrF_i(instrF),
        .iCacheStall_i(iCacheStall),
        .memEn_o(memEn), .memAddr_o(memAddr), .memRdata_i(memRdata),
        .memWen_o(memWen), .memWdata_o(memWdata), .dCacheStall_i(dCacheStall),
        .debugWbPc_o(debugWbPc), .debugWbRfWen_o(debugWbRfWen),
        .debugWbRfWnum_o(debugWbRfWnum), .debugWbRfWdata_o(debugWbRfWdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {opRtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [31:0] target);
        return {opJ, target[27:2]};
    endfunction

    // word array from the reset vector with nops past the end
    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - resetPc;
        if (offset[31:2] < imemWords) begin
            return imem[offset[31:2]];
        end
        return 32'h0000_0000;
    endfunction

    assign instrF   = fetchWord(instAddr);
    assign memRdata = memEn ? dmem[memAddr[7:2]] : 32'hxxxx_xxxx; // data only while enabled

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
        if (got !== expected) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    task automatic checkReg(input logic [4:0] got, input logic [4:0] expected,
                            input string what);
        if (got !== expected) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                               $time, what, got, expected));
        end
    endtask

    task automatic waitRetire(input int idx);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (debugWbRfWen == 4'h0 && cycles < waitLimit);
        if (debugWbRfWen == 4'h0) begin
            abortRun($sformatf("no writeback arrived for retirement %0d within %0d cycles",
                               idx, waitLimit));
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = 32'h0000_0000;
        end
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = 32'hD0D0_0000 | i;
        end
        imem[0]  = iType(opAddiu, 5'd0, 5'd1, 16'd5);
        imem[1]  = iType(opAddiu, 5'd0, 5'd2, 16'hFFFD);
        imem[2]  = rType(5'd1, 5'd2, 5'd3, fnAddu);   // fwd from MEM and WB
        imem[3]  = rType(5'd3, 5'd1, 5'd4, fnSubu);
        imem[4]  = iType(opOri, 5'd0, 5'd5, 16'hF0FF);
        imem[5]  = iType(opLui, 5'd0, 5'd6, 16'h1234);
        imem[6]  = rType(5'd6, 5'd5, 5'd7, fnOr);
        imem[7]  = rType(5'd7, 5'd2, 5'd8, fnAnd);
        imem[8]  = rType(5'd2, 5'd1, 5'd9, fnSlt);
        imem[9]  = rType(5'd1, 5'd2, 5'd10, fnSlt);
        imem[10] = iType(opSw, 5'd0, 5'd7, 16'h0010);
        imem[11] = iType(opLw, 5'd0, 5'd11, 16'h0010);
        imem[12] = rType(5'd11, 5'd1, 5'd12, fnAddu); // load-use
        imem[13] = iType(opAddiu, 5'd0, 5'd0, 16'd7);  // $0 write that never shows in the trace
        imem[14] = rType(5'd0, 5'd1, 5'd13, fnAddu);
        imem[15] = iType(opBeq, 5'd1, 5'd2, 16'd2);    // not taken
        imem[16] = iType(opAddiu, 5'd0, 5'd14, 16'd1);
        imem[17] = iType(opBeq, 5'd1, 5'd1, 16'd2);    // taken to 20
        imem[18] = iType(opAddiu, 5'd0, 5'd15, 16'h0055);
        imem[19] = iType(opAddiu, 5'd0, 5'd16, 16'h0066);
        imem[20] = iType(opAddiu, 5'd0, 5'd17, 16'h0077);
        imem[21] = jType(resetPc + 32'd96);            // to 24
        imem[22] = iType(opAddiu, 5'd0, 5'd18, 16'd1);
        imem[23] = iType(opAddiu, 5'd0, 5'd19, 16'd2);
        imem[24] = iType(opAddiu, 5'd0, 5'd20, 16'd9);
        imem[25] = iType(opSw, 5'd0, 5'd20, 16'h0014);
        imem[26] = iType(opLw, 5'd0, 5'd21, 16'h0014);
        imem[27] = jType(resetPc + 32'd108);           // spin here
    endtask

    // random freeze on about one cycle in eight per cache
    always @(posedge clk) begin
        if (arstN) begin
            iCacheStall <= ($random(seed) & 7) == 0;
            dCacheStall <= ($random(seed) & 7) == 0;
        end
    end

    always @(posedge clk) begin
        if (memWen == 4'hF && !iCacheStall && !dCacheStall) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    // each store counts once in the cycle it leaves MEM
    always @(negedge clk) begin
        if (debugWbRfWen != 4'h0 && (iCacheStall || dCacheStall)) begin
            abortRun("a writeback showed while a cache stall input was high");
        end else if (memWen != 4'h0 && !iCacheStall && !dCacheStall) begin
            if (storeCount >= numStores) begin
                abortRun("a store appeared that the program does not make");
            end else begin
                checkWord({31'd0, memEn}, 32'h0000_0001, "store memory enable");
                checkWord({28'd0, memWen}, 32'h0000_000F, "store byte enables");
                checkWord(memAddr, expStoreAddr[storeCount], "store address");
                checkWord(memWdata, expStoreData[storeCount], "store data");
                storeCount++;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;
        seed        = 32'h1e81_2ea0;
        storeCount  = 0;
        extraWb     = 0;
        loadProgram();

        repeat (9) @(posedge clk);
        @(negedge clk);
        checkWord(instAddr, resetPc, "pc during reset");
        checkWord({22'd0, instEn, memEn, memWen, debugWbRfWen}, 32'd0, "enables during reset");
        @(posedge clk);
        arstN <= 1'b1;

        for (int i = 0; i < numRetire; i++) begin
            waitRetire(i);
            checkWord({28'd0, debugWbRfWen}, 32'h0000_000F,
                      $sformatf("retirement %0d write enable", i));
            checkWord(debugWbPc, expRetire[i].pc, $sformatf("retirement %0d pc", i));
            checkReg(debugWbRfWnum, expRetire[i].num, $sformatf("retirement %0d register", i));
            checkWord(debugWbRfWdata, expRetire[i].data, $sformatf("retirement %0d data", i));
        end

        // program spins on its last jump so the trace must stay quiet
        repeat (40) begin
            @(negedge clk);
            if (debugWbRfWen != 4'h0) begin
                extraWb++;
            end
        end

        if (extraWb != 0) begin
            abortRun("a writeback appeared after the last expected retirement");
        end else if (storeCount != numStores) begin
            abortRun("not every store of the program reached the data memory");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== list.f ====
design/mipsPkg.sv
design/hazardIf.sv
design/pipeReg.sv
design/mainDecoder.sv
design/regFile.sv
design/alu.sv
design/hazardUnit.sv
design/datapath.sv
dv/datapathTb.sv
